//--- verif/funct_generator_stimulus.txt
// Top hex digit is the command: 1 drive, 2 expect, 3 quiet, 4 strobe latency, 0 end.
// Drive 1ECAASNN: en_low E, enh_conf C, amp AA, sel S, hold NN cycles. Expect 2000NNNN: NNNN samples follow.
// Quiet 3NNNDDDD: no strobe for NNN cycles with data_o at DDDD. Latency 4000000K: first strobe on edge K.
// Idle after reset, no output.
11000004 30140000
// Configure amplitude 127, then a sine from address 0 through the wrap past 63.
1017F003 1007F000 40000003 20000042
0000 0C72 18C7 24DD 3099 3BDD 468D 5090 59CC 622B 6998 7000 7554 7987 7C8D 7E62
7EFF 7E62 7C8D 7987 7554 7000 6998 622B 59CC 5090 468D 3BDD 3099 24DD 18C7 0C72
0000 F38D E738 DB22 CF66 C422 B972 AF6F A633 9DD4 9667 8FFF 8AAB 8678 8372 819D
8100 819D 8372 8678 8AAB 8FFF 9667 9DD4 A633 AF6F B972 C422 CF66 DB22 E738 F38D
0000 0C72
// Reconfigure to amplitude -64 while running; sine at addresses 2 and 3 still drains.
101C0003 20000002
18C7 24DD
300224DD
// Restart at address 0 with cosine for addresses 0 to 15.
100C0100 40000003 20000010
C000 C04F C13B C2C2 C4DF C78F CAC9 CE87 D2BF D766 DC72 E1D5 E782 ED6C F383 F9BA
// Triangle for addresses 16 to 39.
100C0200 20000018
0000 FC00 F800 F400 F000 EC00 E800 E400 E000 DC00 D800 D400 D000 CC00 C800 C400
C400 C800 CC00 D000 D400 D800 DC00 E000
// Square for addresses 40 to 63 and 0 to 7.
100C0300 20000020
4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000 4000
4000 4000 4000 4000 4000 4000 4000 4000 C000 C000 C000 C000 C000 C000 C000 C000
// Idle request; addresses 8 and 9 drain, then data_o holds.
110C0304 20000002
C000 C000
300CC000
00000000

//--- compile.f
+incdir+include
src/funct_generator_pkg.sv
src/gen_sequencer.sv
src/wave_table.sv
src/wave_scaler.sv
src/funct_generator.sv
verif/funct_generator_props.sv
verif/funct_generator_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module funct_generator_tb -o funct_generator_sim \
	-f compile.f > build.log 2>&1 &&
	./obj_dir/funct_generator_sim > sim.log 2>&1
grep -qx "Finished with no errors" sim.log 2>/dev/null &&
	echo "PASS: simulation finished cleanly" ||
	{ echo "FAIL: see build.log and sim.log"; exit 1; }

//--- verif/funct_generator_tb.sv
module funct_generator_tb
	import funct_generator_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Room for every command and expected sample in the stimulus file.
	localparam int MEM_DEPTH = 256;

	// Longest wait in cycles for a single write strobe.
	localparam int WAIT_LIMIT = 200;

	// Clock and reset.
	logic clk;
	logic rst;

	// DUT inputs and outputs.
	logic      en_low;
	logic      enh_conf;
	amp_t      amp;
	wave_sel_t sel;
	sample_t   data;
	logic      wr_en;

	// Command words and expected samples, in file order.
	logic [31:0] stim_mem [MEM_DEPTH];

	// Output samples seen with wr_en_o high that are not checked yet.
	sample_t got_q [$];

	// Read position in the stimulus memory and the current command word.
	int          ptr;
	logic [31:0] cmd;
	logic        done;

	funct_generator funct_generator_inst (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low),
		.enh_conf_i (enh_conf),
		.amp_i      (amp),
		.sel_i      (sel),
		.data_o     (data),
		.wr_en_o    (wr_en)
	);

	// The sequencer checks ride along inside every gen_sequencer instance.
	bind gen_sequencer funct_generator_props funct_generator_props_inst (
		.clk          (clk),
		.rst          (rst),
		.state_i      (state_q),
		.addr_i       (addr_o),
		.addr_valid_i (addr_valid_o)
	);

	// Free running clock with a 4 ns period.
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Prints the reason, then the fail line, then ends the run.
	task automatic stop_with(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at time %0d ns: %s expected %0d (0x%h), got %0d (0x%h)",
				$time, what, exp, exp, got, got);
			stop_with("Output sample mismatch");
		end
	endtask

	task automatic check_strobe(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at time %0d ns: %s expected %b, got %b", $time, what, exp, got);
			stop_with("Write strobe mismatch");
		end
	endtask

	// Advances to the next falling edge, where outputs are stable.
	// Any sample written on the last rising edge is queued for checking.
	task automatic tick();
		@(negedge clk);
		if (wr_en === 1'b1) begin
			got_q.push_back(data);
		end
	endtask

	// Sets all inputs from one drive word and holds them for the given cycles.
	// A count of zero leaves the timing to the command that follows.
	task automatic apply_drive(input logic [31:0] word);
		int n;
		en_low   = word[24];
		enh_conf = word[20];
		amp      = word[19:12];
		sel      = wave_sel_t'(word[9:8]);
		n        = int'(word[7:0]);
		for (int i = 0; i < n; i++) begin
			tick();
		end
	endtask

	// Compares the next output samples in order with the values after the command.
	task automatic expect_samples(input int count);
		int      waited;
		sample_t exp_val;
		sample_t got_val;
		for (int i = 0; i < count; i++) begin
			exp_val = sample_t'(stim_mem[ptr][15:0]);
			ptr++;
			waited = 0;
			while (got_q.size() == 0) begin
				if (waited >= WAIT_LIMIT) begin
					stop_with("Timed out waiting for wr_en_o");
				end
				tick();
				waited++;
			end
			got_val = got_q.pop_front();
			check_sample(got_val, exp_val, $sformatf("data_o sample %0d of %0d", i, count));
		end
	endtask

	// No strobe may appear for the given cycles, and data_o keeps the given value.
	task automatic check_quiet(input logic [31:0] word);
		int      n;
		sample_t held;
		n    = int'(word[27:16]);
		held = sample_t'(word[15:0]);
		if (got_q.size() != 0) begin
			stop_with("A write strobe arrived that the stimulus did not expect");
		end
		for (int i = 0; i < n; i++) begin
			tick();
			check_strobe(wr_en, 1'b0, "wr_en_o while quiet");
			check_sample(data, held, "held data_o");
		end
	endtask

	// The first strobe must land exactly on the given falling edge after the last drive.
	task automatic check_latency(input int cycles);
		for (int i = 1; i <= cycles; i++) begin
			tick();
			check_strobe(wr_en, (i == cycles), $sformatf("wr_en_o at edge %0d of run", i));
		end
	endtask

	initial begin
		rst      = 1'b1;
		en_low   = 1'b1;
		enh_conf = 1'b0;
		amp      = '0;
		sel      = WAVE_SINE;
		ptr      = 0;
		done     = 1'b0;
		for (int i = 0; i < MEM_DEPTH; i++) begin
			stim_mem[i] = '0;
		end
		$readmemh("verif/funct_generator_stimulus.txt", stim_mem);
		if (stim_mem[0] == '0) begin
			stop_with("The stimulus file is missing or empty");
		end

		// Ten rising edges in reset, released on a falling edge.
		for (int i = 0; i < 10; i++) begin
			tick();
		end
		rst = 1'b0;

		// The top digit of each command word selects the action.
		while (!done) begin
			if (ptr >= MEM_DEPTH) begin
				stop_with("The stimulus ran past the end of memory without an end command");
			end
			cmd = stim_mem[ptr];
			ptr++;
			case (cmd[31:28])
				4'h0: done = 1'b1;
				4'h1: apply_drive(cmd);
				4'h2: expect_samples(int'(cmd[15:0]));
				4'h3: check_quiet(cmd);
				4'h4: check_latency(int'(cmd[15:0]));
				default: stop_with("Unknown command word in the stimulus file");
			endcase
		end

		// Every strobe of the run must have been matched against the file.
		if (got_q.size() == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("%0d output samples were never checked", got_q.size());
			$display("Finished with errors");
			$fatal(1, "Unchecked output samples remain");
		end
	end

endmodule

//--- verif/funct_generator_props.sv
module funct_generator_props
	import funct_generator_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input gen_state_t  state_i,
	input table_addr_t addr_i,
	input logic        addr_valid_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// A cycle spent in reset leaves the FSM in idle, so no address is issued next cycle.
	reset_no_valid_a: assert property (@(posedge clk) rst |=> !addr_valid_i)
		else $error("addr_valid_o is high in the cycle after reset");

	// Outside generation the counter sits at zero.
	// Every new run therefore starts at the first table entry.
	addr_zero_a: assert property (
		@(posedge clk) disable iff (rst)
		(state_i != GEN_RUN) |-> (addr_i == '0)
	) else $error("address is not zero in idle or configure");

	// Two generate cycles in a row step the address by exactly one.
	// The six bit counter wraps from 63 to 0 on its own.
	addr_step_a: assert property (
		@(posedge clk) disable iff (rst)
		((state_i == GEN_RUN) && ($past(state_i) == GEN_RUN))
			|-> (addr_i == table_addr_t'($past(addr_i) + table_addr_t'(1)))
	) else $error("address did not advance by one during generate");

endmodule

//--- src/funct_generator.sv
module funct_generator
	import funct_generator_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      en_low_i,
	input  logic      enh_conf_i,
	input  amp_t      amp_i,
	input  wave_sel_t sel_i,
	output sample_t   data_o,
	output logic      wr_en_o
);

	// Sequencer to table.
	table_addr_t addr;
	logic        addr_valid;

	// Sequencer to scaler.
	amp_t amp;

	// Table to scaler.
	sample_t sine;
	sample_t cosine;
	sample_t triangle;
	sample_t square;
	logic    samples_valid;

	// Control FSM, address counter and amplitude register.
	gen_sequencer gen_sequencer_inst (
		.clk          (clk),
		.rst          (rst),
		.en_low_i     (en_low_i),
		.enh_conf_i   (enh_conf_i),
		.amp_i        (amp_i),
		.addr_o       (addr),
		.addr_valid_o (addr_valid),
		.amp_o        (amp)
	);

	// Waveform lookup, one cycle behind the address.
	wave_table wave_table_inst (
		.clk             (clk),
		.rst             (rst),
		.addr_i          (addr),
		.addr_valid_i    (addr_valid),
		.sine_o          (sine),
		.cosine_o        (cosine),
		.triangle_o      (triangle),
		.square_o        (square),
		.samples_valid_o (samples_valid)
	);

	// Selection and scaling, one more cycle to the output strobe.
	wave_scaler wave_scaler_inst (
		.clk             (clk),
		.rst             (rst),
		.sine_i          (sine),
		.cosine_i        (cosine),
		.triangle_i      (triangle),
		.square_i        (square),
		.samples_valid_i (samples_valid),
		.sel_i           (sel_i),
		.amp_i           (amp),
		.data_o          (data_o),
		.wr_en_o         (wr_en_o)
	);

endmodule

//--- src/wave_scaler.sv
`include "funct_generator_params.svh"

module wave_scaler
	import funct_generator_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  sample_t   sine_i,
	input  sample_t   cosine_i,
	input  sample_t   triangle_i,
	input  sample_t   square_i,
	input  logic      samples_valid_i,
	input  wave_sel_t sel_i,
	input  amp_t      amp_i,
	output sample_t   data_o,
	output logic      wr_en_o
);

	// Full precision product width of a sample and an amplitude.
	localparam int PROD_WIDTH = `DATA_WIDTH + `AMP_WIDTH;

	// Sample chosen by the selector.
	sample_t selected;

	// Signed product and its scaled version.
	logic signed [PROD_WIDTH-1:0] product;
	logic signed [PROD_WIDTH-1:0] scaled;

	// Output registers.
	sample_t data_q;
	logic    wr_en_q;

	// Waveform select.
	always_comb begin
		selected = sine_i;
		case (sel_i)
			WAVE_SINE:     selected = sine_i;
			WAVE_COSINE:   selected = cosine_i;
			WAVE_TRIANGLE: selected = triangle_i;
			WAVE_SQUARE:   selected = square_i;
			default:       selected = sine_i;
		endcase
	end

	// Both operands are signed, so they are sign extended to the product width.
	assign product = PROD_WIDTH'(selected) * PROD_WIDTH'(amp_i);

	// The arithmetic shift keeps the sign while dividing by the amplitude scale.
	assign scaled = product >>> `AMP_SHIFT;

	// The scaled value is truncated to the sample width on capture.
	// data_o holds its last value between strobes.
	always_ff @(posedge clk) begin
		if (rst) begin
			data_q <= '0;
		end else if (samples_valid_i) begin
			data_q <= scaled[`DATA_WIDTH-1:0];
		end
	end

	// One strobe for every valid sample set.
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= samples_valid_i;
		end
	end

	assign data_o  = data_q;
	assign wr_en_o = wr_en_q;

endmodule

//--- src/wave_table.sv
`include "funct_generator_params.svh"

module wave_table
	import funct_generator_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  table_addr_t addr_i,
	input  logic        addr_valid_i,
	output sample_t     sine_o,
	output sample_t     cosine_o,
	output sample_t     triangle_o,
	output sample_t     square_o,
	output logic        samples_valid_o
);

	// One full period of a sine at full scale, 64 points.
	// Entry k holds round(32767 * sin(2 * pi * k / 64)).
	localparam sample_t SINE_LUT [2**`LUT_ADDR] = '{
		16'sd0,      16'sd3212,   16'sd6393,   16'sd9512,
		16'sd12539,  16'sd15446,  16'sd18204,  16'sd20787,
		16'sd23170,  16'sd25329,  16'sd27245,  16'sd28898,
		16'sd30273,  16'sd31356,  16'sd32137,  16'sd32609,
		16'sd32767,  16'sd32609,  16'sd32137,  16'sd31356,
		16'sd30273,  16'sd28898,  16'sd27245,  16'sd25329,
		16'sd23170,  16'sd20787,  16'sd18204,  16'sd15446,
		16'sd12539,  16'sd9512,   16'sd6393,   16'sd3212,
		16'sd0,      -16'sd3212,  -16'sd6393,  -16'sd9512,
		-16'sd12539, -16'sd15446, -16'sd18204, -16'sd20787,
		-16'sd23170, -16'sd25329, -16'sd27245, -16'sd28898,
		-16'sd30273, -16'sd31356, -16'sd32137, -16'sd32609,
		-16'sd32767, -16'sd32609, -16'sd32137, -16'sd31356,
		-16'sd30273, -16'sd28898, -16'sd27245, -16'sd25329,
		-16'sd23170, -16'sd20787, -16'sd18204, -16'sd15446,
		-16'sd12539, -16'sd9512,  -16'sd6393,  -16'sd3212
	};

	// A quarter period in table entries.
	localparam table_addr_t QUARTER = table_addr_t'(2**(`LUT_ADDR-2));

	// Full scale levels used by the square wave.
	localparam sample_t POS_FULL = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
	localparam sample_t NEG_FULL = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

	// The cosine reads the sine table a quarter period ahead.
	// The address sum wraps naturally at the table size.
	table_addr_t cos_addr;

	// Position inside the rising or falling half of the triangle.
	logic [`LUT_ADDR-2:0] tri_idx;

	// Triangle level in offset binary, before the sign flip.
	logic [`DATA_WIDTH-1:0] tri_level;

	// Combinational samples for the current address.
	sample_t triangle_d;
	sample_t square_d;

	// Sample registers.
	sample_t sine_q;
	sample_t cosine_q;
	sample_t triangle_q;
	sample_t square_q;
	logic    valid_q;

	assign cos_addr = addr_i + QUARTER;

	// In the first half the low address bits count up.
	// In the second half their inverse counts down, which mirrors the ramp.
	assign tri_idx = addr_i[`LUT_ADDR-1] ? ~addr_i[`LUT_ADDR-2:0] : addr_i[`LUT_ADDR-2:0];

	// Each step of the index is one fixed slice of the full range.
	assign tri_level = {tri_idx, {(`DATA_WIDTH-`LUT_ADDR+1){1'b0}}};

	// Flipping the top bit turns offset binary into two's complement.
	// The ramp then spans from negative full scale upwards.
	assign triangle_d = {~tri_level[`DATA_WIDTH-1], tri_level[`DATA_WIDTH-2:0]};

	// High for the first half period and low for the second.
	assign square_d = addr_i[`LUT_ADDR-1] ? NEG_FULL : POS_FULL;

	// Samples are captured only for a valid address and hold otherwise.
	always_ff @(posedge clk) begin
		if (addr_valid_i) begin
			sine_q     <= SINE_LUT[addr_i];
			cosine_q   <= SINE_LUT[cos_addr];
			triangle_q <= triangle_d;
			square_q   <= square_d;
		end
	end

	// The valid flag trails the address valid by one cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= addr_valid_i;
		end
	end

	assign sine_o          = sine_q;
	assign cosine_o        = cosine_q;
	assign triangle_o      = triangle_q;
	assign square_o        = square_q;
	assign samples_valid_o = valid_q;

endmodule

//--- src/gen_sequencer.sv
module gen_sequencer
	import funct_generator_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        en_low_i,
	input  logic        enh_conf_i,
	input  amp_t        amp_i,
	output table_addr_t addr_o,
	output logic        addr_valid_o,
	output amp_t        amp_o
);

	// Current and next state of the control FSM.
	gen_state_t state_q;
	gen_state_t state_d;

	// Table address counter and its next value.
	table_addr_t addr_q;
	table_addr_t addr_d;

	// Amplitude captured during configuration.
	amp_t amp_q;

	// Next state logic.
	// A configure request always wins over an idle request.
	// With neither request pending, the FSM heads for generation.
	always_comb begin
		state_d = state_q;
		case (state_q)
			GEN_IDLE: begin
				if (enh_conf_i) begin
					state_d = GEN_CONFIG;
				end else if (!en_low_i) begin
					state_d = GEN_RUN;
				end else begin
					state_d = GEN_IDLE;
				end
			end
			GEN_CONFIG: begin
				// A held configure request keeps the FSM here.
				if (enh_conf_i) begin
					state_d = GEN_CONFIG;
				end else if (en_low_i) begin
					state_d = GEN_IDLE;
				end else begin
					state_d = GEN_RUN;
				end
			end
			GEN_RUN: begin
				if (enh_conf_i) begin
					state_d = GEN_CONFIG;
				end else if (en_low_i) begin
					state_d = GEN_IDLE;
				end else begin
					state_d = GEN_RUN;
				end
			end
			default: begin
				// The unused encoding recovers to idle.
				state_d = GEN_IDLE;
			end
		endcase
	end

	// State register.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= GEN_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Next address.
	// The counter only advances while the FSM stays in generation.
	// On any exit from generation the address is cleared on the same edge, so
	// it already reads zero in the first idle or configure cycle.
	// The six bit counter wraps from 63 back to 0 by itself.
	always_comb begin
		if ((state_q == GEN_RUN) && (state_d == GEN_RUN)) begin
			addr_d = addr_q + table_addr_t'(1);
		end else begin
			addr_d = '0;
		end
	end

	// Address counter register.
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= '0;
		end else begin
			addr_q <= addr_d;
		end
	end

	// Amplitude register.
	// It follows amp_i on every configure cycle and holds otherwise.
	// The value present on the last configure cycle is the one used for
	// generation.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= '0;
		end else if (state_q == GEN_CONFIG) begin
			amp_q <= amp_i;
		end
	end

	// Outputs come straight from registered state.
	// An address is valid exactly while the FSM is in generation.
	assign addr_o       = addr_q;
	assign addr_valid_o = (state_q == GEN_RUN);
	assign amp_o        = amp_q;

endmodule

//--- src/funct_generator_pkg.sv
`include "funct_generator_params.svh"

package funct_generator_pkg;

	// States of the control FSM.
	// The fourth code is unused and falls back to idle.
	typedef enum logic [1:0] {
		GEN_IDLE,
		GEN_CONFIG,
		GEN_RUN
	} gen_state_t;

	// Waveform select codes, in the order of the external selector input.
	typedef enum logic [1:0] {
		WAVE_SINE,
		WAVE_COSINE,
		WAVE_TRIANGLE,
		WAVE_SQUARE
	} wave_sel_t;

	// Signed two's complement sample.
	typedef logic signed [`DATA_WIDTH-1:0] sample_t;

	// Signed amplitude, read as a fraction of full scale.
	typedef logic signed [`AMP_WIDTH-1:0] amp_t;

	// Unsigned waveform table address.
	typedef logic [`LUT_ADDR-1:0] table_addr_t;

endpackage

//--- include/funct_generator_params.svh
`ifndef FUNCT_GENERATOR_PARAMS_SVH
`define FUNCT_GENERATOR_PARAMS_SVH

// Width of every waveform sample and of the generator output.
`define DATA_WIDTH 16

// Width of the signed amplitude.
// The amplitude is a fraction of full scale, so 127 is close to unity gain.
`define AMP_WIDTH 8

// Width of the waveform table address.
// Six bits give 64 points in one period.
`define LUT_ADDR 6

// Arithmetic right shift applied to the sample times amplitude product.
// It matches the fractional reading of the amplitude.
`define AMP_SHIFT 7

`endif
